// ==== flist.f ====
logic/uart_pkg.sv
logic/sync_fifo.sv
logic/baud_gen.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_regs.sv
logic/uart_top.sv
verif/uart_properties.sv
verif/uart_checker.sv
verif/uart_tb.sv

// ==== verif/uart_golden.txt ====
# op addr data in hex: W write, R read and expected word, T expected txd byte
# C wait data clocks, Q wait until the receive FIFO holds data bytes
R 6 0000003f
R 2 00000000
R 3 00000000
R 4 00000000
R 7 00000000
W 2 00030000
R 2 00030000
W 3 00020001
R 3 00020001
W 4 00000003
R 4 00000003
R 5 00000001
W 0 000000a5
W 0 0000003c
R 5 00000001
W 0 00000081
R 5 00000000
W 0 0000005e
R 0 80000000
W 0 000000ff
W 2 00030001
T 0 a5
T 0 3c
T 0 81
T 0 5e
Q 0 4
R 5 00000003
R 1 000000a5
R 1 0000003c
R 5 00000001
R 1 00000081
R 1 0000005e
R 1 80000000
W 6 0000001f
R 6 0000001f
C 0 00000008
W 2 00030003
R 2 00030003
W 0 000000c3
T 0 c3
Q 0 1
R 1 000000c3

// ==== verif/uart_tb.sv ====
// Run from the project root; FIFOs are 4 deep here so a full FIFO takes only 4 writes
`timescale 1ns/1ps
`default_nettype none

module uart_tb import uart_pkg::*; ();

  typedef struct packed {
    logic [7:0]  op;
    logic [2:0]  addr;
    logic [31:0] data;
  } golden_op_t;

  localparam int CLK_NS = 8;
  localparam int DEPTH = 4;
  localparam int DIV_RESET = 63;

  logic        clock = 1'b0;
  logic        reset;
  bus_req_t    req;
  logic [31:0] rd_data;
  logic        txd;
  int          errors;
  int          reads_checked;
  int          frames_checked;
  int          frames_expected = 0;
  int          limit_cycles = 2000;
  golden_op_t  ops[$];

  always #(CLK_NS / 2) clock = ~clock;

  // Serial output loops straight back into the receiver
  uart_top #(.FIFO_DEPTH(DEPTH), .DIV_RESET(DIV_RESET)) u_dut (
    .clock, .reset, .req, .rd_data, .rxd(txd), .txd
  );

  uart_checker #(.DIV_RESET(DIV_RESET)) u_chk (
    .clock, .reset, .req, .rd_data, .txd, .errors, .reads_checked, .frames_checked
  );

  task automatic load_golden();
    int          fd;
    int          period;
    byte         op;
    logic [31:0] a;
    logic [31:0] d;
    string       line;
    period = DIV_RESET + 1;
    fd = $fopen("verif/uart_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open verif/uart_golden.txt from the working directory");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%c %h %h", op, a, d) == 3 && op != "#") begin
          ops.push_back('{op: op, addr: a[2:0], data: d});
          limit_cycles += 4;
          if (op == "C") limit_cycles += int'(d);
          if (op == "W" && a == 6) period = int'(d[15:0]) + 1;
          // Room for two stop bits and the idle gap
          if (op == "T") begin
            limit_cycles += 12 * period;
            frames_expected++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_op(input golden_op_t g);
    @(posedge clock);
    #1;
    req = '0;
    case (g.op)
      "W": begin
        req.wr_en   = 1'b1;
        req.addr    = reg_addr_e'(g.addr);
        req.wr_data = g.data;
      end
      "R": begin
        req.rd_en = 1'b1;
        req.addr  = reg_addr_e'(g.addr);
      end
      "C": repeat (g.data) @(posedge clock);
      "Q": while (u_dut.rx_count != g.data) begin
        @(posedge clock);
        #1;
      end
      default: ;
    endcase
  endtask

  initial begin
    reset = 1'b1;
    req   = '0;
    load_golden();
    repeat (4) @(posedge clock);
    #1 reset = 1'b0;
    foreach (ops[i]) run_op(ops[i]);
    @(posedge clock);
    #1 req = '0;
    // Last frame may still be on the line
    wait (frames_checked == frames_expected);
    repeat (4) @(posedge clock);
    $display("Checked %0d reads and %0d frames: %0d errors, %0d assertion failures",
             reads_checked, frames_checked, errors, u_dut.u_props.failures);
    if (errors == 0 && u_dut.u_props.failures == 0 && ops.size() > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #1;
    #(limit_cycles * CLK_NS);
    $display("Timeout: the run did not complete within %0d clock cycles", limit_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/uart_checker.sv ====
// Decodes txd at the period of the last divisor write; divisor must only change while txd idles
`timescale 1ns/1ps
`default_nettype none

module uart_checker import uart_pkg::*; #(
  parameter int DIV_RESET = 63
) (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire bus_req_t    req,
  input  wire logic [31:0] rd_data,
  input  wire logic        txd,
  output int               errors,
  output int               reads_checked,
  output int               frames_checked
);

  logic [31:0] exp_rd[$];
  logic [7:0]  exp_tx[$];
  logic [31:0] want;
  logic [2:0]  want_addr;
  logic        pending = 1'b0;
  logic        two_stop = 1'b0;
  int          period = DIV_RESET + 1;
  int          rd_errors = 0;
  int          tx_errors = 0;
  int          rd_count = 0;
  int          frame_count = 0;

  assign errors         = rd_errors + tx_errors;
  assign reads_checked  = rd_count;
  assign frames_checked = frame_count;

  initial begin : load_expected
    int          fd;
    byte         op;
    logic [31:0] a;
    logic [31:0] d;
    string       line;
    fd = $fopen("verif/uart_golden.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%c %h %h", op, a, d) == 3) begin
          if (op == "R") exp_rd.push_back(d);
          if (op == "T") exp_tx.push_back(d[7:0]);
        end
      end
      $fclose(fd);
    end
  end

  // Bit period and stop length follow the host writes
  always @(posedge clock) begin
    if (!reset && req.wr_en && req.addr == ADDR_DIV) period = int'(req.wr_data[15:0]) + 1;
    if (!reset && req.wr_en && req.addr == ADDR_TXCTRL) two_stop = req.wr_data[1];
  end

  // Read word is registered, so it is compared one cycle after the strobe
  always @(posedge clock) begin
    if (pending) begin
      rd_count++;
      if (rd_data !== want) begin
        rd_errors++;
        $display("Error at %0t ns: read of slot %0d returned %h, expected %h",
                 $time, want_addr, rd_data, want);
      end
    end
    pending = !reset && req.rd_en;
    if (pending) begin
      want_addr = req.addr;
      if (exp_rd.size() == 0) begin
        rd_errors++;
        pending = 1'b0;
        $display("Read strobe at %0t ns has no expected value in the golden file", $time);
      end else begin
        want = exp_rd.pop_front();
      end
    end
  end

  // Entered one cycle after the falling edge of the start bit
  task automatic decode_frame();
    int         p;
    logic       two;
    logic       framing_ok;
    logic [7:0] got;
    logic [7:0] exp;
    p = period;
    two = two_stop;
    repeat (p / 2) @(posedge clock);
    framing_ok = !txd;
    for (int k = 0; k < 8; k++) begin
      repeat (p) @(posedge clock);
      got[k] = txd;
    end
    repeat (p) @(posedge clock);
    framing_ok &= txd;
    if (two) begin
      repeat (p) @(posedge clock);
      framing_ok &= txd;
    end
    if (exp_tx.size() == 0) begin
      tx_errors++;
      $display("Unexpected frame %h appeared on txd at %0t ns", got, $time);
    end else begin
      exp = exp_tx.pop_front();
      if (got !== exp || !framing_ok) begin
        tx_errors++;
        $display("Error at %0t ns: txd frame %h with framing %0b, expected %h",
                 $time, got, framing_ok, exp);
      end
    end
    frame_count++;
  endtask

  always begin
    @(posedge clock);
    if (!reset && !txd) decode_frame();
  end

endmodule

`default_nettype wire

// ==== verif/uart_properties.sv ====
// Bound into uart_top; CNT_W must match the FIFO count width of the top level
`timescale 1ns/1ps
`default_nettype none

module uart_properties import uart_pkg::*; #(
  parameter int CNT_W = 4
) (
  input wire logic             clock,
  input wire logic             reset,
  input wire bus_req_t         req,
  input wire logic             txd,
  input wire logic             tx_push,
  input wire logic             tx_full,
  input wire logic [CNT_W-1:0] tx_count
);

  int failures = 0;

  no_dual_strobe: assert property (@(posedge clock) disable iff (reset)
    !(req.rd_en && req.wr_en))
    else begin
      failures++;
      $error("rd_en and wr_en high in the same cycle");
    end

  txd_idle_in_reset: assert property (@(posedge clock) reset |-> txd)
    else begin
      failures++;
      $error("txd low while reset is asserted");
    end

  // A push into a full FIFO must not raise the count
  no_push_when_full: assert property (@(posedge clock) disable iff (reset)
    tx_push && tx_full |=> tx_count <= $past(tx_count))
    else begin
      failures++;
      $error("transmit FIFO accepted a push while full");
    end

endmodule

bind uart_top uart_properties #(.CNT_W(CNT_W)) u_props (.*);

`default_nettype wire

// ==== logic/uart_top.sv ====
// UART top level; no interrupt pin, the host polls the pending register
`timescale 1ns/1ps
`default_nettype none

module uart_top import uart_pkg::*; #(
  parameter int FIFO_DEPTH = 8,
  parameter int unsigned DIV_RESET = 63,
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1)
) (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire bus_req_t    req,
  output logic      [31:0] rd_data,
  input  wire logic        rxd,
  output logic             txd
);

  uart_cfg_t         cfg;
  logic              tx_push;
  logic [DATA_W-1:0] tx_push_data;
  logic              tx_pop;
  logic [DATA_W-1:0] tx_head;
  logic              tx_empty;
  logic              tx_full;
  logic [CNT_W-1:0]  tx_count;
  logic              rx_pop;
  logic [DATA_W-1:0] rx_head;
  logic              rx_empty;
  logic [CNT_W-1:0]  rx_count;
  logic              rx_valid;
  logic [DATA_W-1:0] rx_byte;
  logic              bit_tick;
  logic              sample_tick;

  uart_regs #(.DIV_RESET(DIV_RESET), .FIFO_DEPTH(FIFO_DEPTH)) u_regs (
    .clock, .reset, .req, .rd_data, .cfg,
    .tx_push, .tx_push_data, .tx_full, .tx_count,
    .rx_pop, .rx_head, .rx_empty, .rx_count
  );

  sync_fifo #(.DEPTH(FIFO_DEPTH)) u_tx_fifo (
    .clock, .reset, .push(tx_push), .push_data(tx_push_data), .pop(tx_pop),
    .head(tx_head), .empty(tx_empty), .full(tx_full), .count(tx_count)
  );

  // Receive side has no full flag consumer; the FIFO drops the byte itself
  sync_fifo #(.DEPTH(FIFO_DEPTH)) u_rx_fifo (
    .clock, .reset, .push(rx_valid), .push_data(rx_byte), .pop(rx_pop),
    .head(rx_head), .empty(rx_empty), .full(), .count(rx_count)
  );

  baud_gen u_baud (.clock, .reset, .div(cfg.div), .bit_tick, .sample_tick);

  uart_tx u_tx (
    .clock, .reset, .bit_tick, .txen(cfg.txen), .nstop(cfg.nstop),
    .fifo_empty(tx_empty), .fifo_head(tx_head), .fifo_pop(tx_pop), .txd
  );

  uart_rx u_rx (.clock, .reset, .sample_tick, .rxen(cfg.rxen), .rxd, .rx_valid, .rx_byte);

endmodule

`default_nettype wire

// ==== logic/uart_regs.sv ====
// Register file with one-cycle access; writes to read-only or reserved slots are ignored
`timescale 1ns/1ps
`default_nettype none

module uart_regs import uart_pkg::*; #(
  parameter int unsigned DIV_RESET = 63,
  parameter int FIFO_DEPTH = 8,
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1)
) (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire bus_req_t          req,
  output logic      [31:0]       rd_data,
  output uart_cfg_t              cfg,
  output logic                   tx_push,
  output logic      [DATA_W-1:0] tx_push_data,
  input  wire logic              tx_full,
  input  wire logic [CNT_W-1:0]  tx_count,
  output logic                   rx_pop,
  input  wire logic [DATA_W-1:0] rx_head,
  input  wire logic              rx_empty,
  input  wire logic [CNT_W-1:0]  rx_count
);

  logic              txwm_pend;
  logic              rxwm_pend;
  logic [DATA_W-1:0] rx_rd_byte;
  logic [31:0]       rd_word;

  // FIFO strobes come straight off the bus
  assign tx_push      = req.wr_en && (req.addr == ADDR_TXDATA);
  assign tx_push_data = req.wr_data[DATA_W-1:0];
  assign rx_pop       = req.rd_en && (req.addr == ADDR_RXDATA);

  // Watermarks compared at full width
  assign txwm_pend = cfg.ie_txwm && (int'(tx_count) < int'(cfg.txcnt));
  assign rxwm_pend = cfg.ie_rxwm && (int'(rx_count) > int'(cfg.rxcnt));

  // Head is valid before the pop, zero when nothing is queued
  assign rx_rd_byte = rx_empty ? '0 : rx_head;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      cfg     <= '0;
      cfg.div <= 16'(DIV_RESET);
    end else if (req.wr_en) begin
      case (req.addr)
        ADDR_TXCTRL: begin
          cfg.txen  <= req.wr_data[0];
          cfg.nstop <= req.wr_data[1];
          cfg.txcnt <= req.wr_data[18:16];
        end
        ADDR_RXCTRL: begin
          cfg.rxen  <= req.wr_data[0];
          cfg.rxcnt <= req.wr_data[18:16];
        end
        ADDR_IE: begin
          cfg.ie_txwm <= req.wr_data[0];
          cfg.ie_rxwm <= req.wr_data[1];
        end
        ADDR_DIV: cfg.div <= req.wr_data[15:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (req.addr)
      ADDR_TXDATA: rd_word = {tx_full, 31'b0};
      ADDR_RXDATA: rd_word = {rx_empty, 23'b0, rx_rd_byte};
      ADDR_TXCTRL: rd_word = {13'b0, cfg.txcnt, 14'b0, cfg.nstop, cfg.txen};
      ADDR_RXCTRL: rd_word = {13'b0, cfg.rxcnt, 15'b0, cfg.rxen};
      ADDR_IE:     rd_word = {30'b0, cfg.ie_rxwm, cfg.ie_txwm};
      ADDR_IP:     rd_word = {30'b0, rxwm_pend, txwm_pend};
      ADDR_DIV:    rd_word = {16'b0, cfg.div};
      default:     rd_word = 32'b0;
    endcase
  end

  // Read word holds until the next read
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rd_data <= '0;
    end else if (req.rd_en) begin
      rd_data <= rd_word;
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
// 16x oversampling receiver; no error reporting, a frame with a low stop bit is dropped
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire logic              sample_tick,
  input  wire logic              rxen,
  input  wire logic              rxd,
  output logic                   rx_valid,
  output logic      [DATA_W-1:0] rx_byte
);

  rx_state_e         state;
  logic [1:0]        sync_q;
  logic              rxd_s;
  logic [3:0]        sample_cnt;
  logic [2:0]        bit_idx;
  logic [DATA_W-1:0] shift_q;

  assign rxd_s   = sync_q[1];
  assign rx_byte = shift_q;

  // Line idles high, so the synchronizer resets to one
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], rxd};
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clock) begin
    if (state == RX_DATA && sample_tick && sample_cnt == 4'd15) begin
      shift_q <= {rxd_s, shift_q[DATA_W-1:1]};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state      <= RX_IDLE;
      sample_cnt <= '0;
      bit_idx    <= '0;
      rx_valid   <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: if (sample_tick && rxen && !rxd_s) begin
          sample_cnt <= '0;
          state      <= RX_START;
        end
        // Low still at sample 8 means a real start bit
        RX_START: if (sample_tick) begin
          sample_cnt <= sample_cnt + 1'b1;
          if (sample_cnt == 4'd7) begin
            sample_cnt <= '0;
            bit_idx    <= '0;
            state      <= rxd_s ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: if (sample_tick) begin
          sample_cnt <= sample_cnt + 1'b1;
          if (sample_cnt == 4'd15) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= RX_STOP;
          end
        end
        RX_STOP: if (sample_tick) begin
          sample_cnt <= sample_cnt + 1'b1;
          if (sample_cnt == 4'd15) begin
            rx_valid <= rxd_s;
            state    <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
// 8N1 or 8N2 serializer; the FIFO must present its head in the cycle fifo_pop is high
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire logic              bit_tick,
  input  wire logic              txen,
  input  wire logic              nstop,
  input  wire logic              fifo_empty,
  input  wire logic [DATA_W-1:0] fifo_head,
  output logic                   fifo_pop,
  output logic                   txd
);

  tx_state_e         state;
  logic [DATA_W-1:0] shift_q;
  logic [2:0]        bit_idx;
  logic [1:0]        stop_cnt;
  logic [1:0]        stop_len;

  assign stop_len = nstop ? 2'd2 : 2'd1;
  assign fifo_pop = (state == TX_IDLE) && txen && !fifo_empty;

  always_ff @(posedge clock) begin
    if (fifo_pop) begin
      shift_q <= fifo_head;
    end else if (state == TX_DATA && bit_tick) begin
      shift_q <= shift_q >> 1;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state    <= TX_IDLE;
      txd      <= 1'b1;
      bit_idx  <= '0;
      stop_cnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          txd <= 1'b1;
          if (fifo_pop) state <= TX_START;
        end
        // Start bit is aligned to the next tick
        TX_START: if (bit_tick) begin
          txd     <= 1'b0;
          bit_idx <= '0;
          state   <= TX_DATA;
        end
        TX_DATA: if (bit_tick) begin
          txd     <= shift_q[0];
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) begin
            stop_cnt <= '0;
            state    <= TX_STOP;
          end
        end
        // First tick here ends the last data bit
        TX_STOP: if (bit_tick) begin
          txd      <= 1'b1;
          stop_cnt <= stop_cnt + 1'b1;
          if (stop_cnt == stop_len) state <= TX_IDLE;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/baud_gen.sv ====
// Tick strobes in the system clock domain; sample rate assumes div+1 is close to a multiple of 16
`timescale 1ns/1ps
`default_nettype none

module baud_gen (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire logic [15:0] div,
  output logic             bit_tick,
  output logic             sample_tick
);

  logic [15:0] div_q;
  logic [15:0] bit_cnt;
  logic [11:0] sample_cnt;
  logic        div_change;

  // Any new divisor restarts both periods
  assign div_change = (div != div_q);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      div_q       <= '0;
      bit_cnt     <= '0;
      sample_cnt  <= '0;
      bit_tick    <= 1'b0;
      sample_tick <= 1'b0;
    end else begin
      div_q       <= div;
      bit_tick    <= 1'b0;
      sample_tick <= 1'b0;
      if (div_change || bit_cnt == div) begin
        bit_cnt  <= '0;
        bit_tick <= !div_change;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      // Sample period is the divisor over sixteen
      if (div_change || sample_cnt == div[15:4]) begin
        sample_cnt  <= '0;
        sample_tick <= !div_change;
      end else begin
        sample_cnt <= sample_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/sync_fifo.sv ====
// First-word-fall-through byte FIFO; DEPTH must be a power of two, push when full is dropped
`timescale 1ns/1ps
`default_nettype none

module sync_fifo import uart_pkg::*; #(
  parameter int DEPTH = 8,
  localparam int PTR_W = $clog2(DEPTH),
  localparam int CNT_W = $clog2(DEPTH + 1)
) (
  input  wire logic              clock,
  input  wire logic              reset,
  input  wire logic              push,
  input  wire logic [DATA_W-1:0] push_data,
  input  wire logic              pop,
  output logic      [DATA_W-1:0] head,
  output logic                   empty,
  output logic                   full,
  output logic      [CNT_W-1:0]  count
);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic              push_ok;
  logic              pop_ok;

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;

  // Oldest entry is always visible
  assign head = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart_pkg.sv ====
// Shared UART types; register slots are word indices, so the host bus carries a 3-bit address
`default_nettype none

package uart_pkg;

  // Byte width of both FIFOs and the serial payload
  localparam int DATA_W = 8;

  // Register slots seen by the host
  typedef enum logic [2:0] {
    ADDR_TXDATA = 3'd0,
    ADDR_RXDATA = 3'd1,
    ADDR_TXCTRL = 3'd2,
    ADDR_RXCTRL = 3'd3,
    ADDR_IE     = 3'd4,
    ADDR_IP     = 3'd5,
    ADDR_DIV    = 3'd6,
    ADDR_RSVD   = 3'd7
  } reg_addr_e;

  // One single-cycle bus request
  typedef struct packed {
    logic        rd_en;
    logic        wr_en;
    reg_addr_e   addr;
    logic [31:0] wr_data;
  } bus_req_t;

  // Programmed configuration fanned out to the datapath
  typedef struct packed {
    logic        txen;
    logic        nstop;
    logic [2:0]  txcnt;
    logic        rxen;
    logic [2:0]  rxcnt;
    logic        ie_txwm;
    logic        ie_rxwm;
    logic [15:0] div;
  } uart_cfg_t;

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

`default_nettype wire
